//--- source/board_shell_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared constants of the board shell, the register address map
// and the packed bus types of the register and SPI interfaces
//////////////////////////////////////////////////////////////////////

package board_shell_pkg;

  // Clocking, RTC runs at 1 MHz off the 50 MHz SoC clock
  localparam int unsigned SocClkHz      = 50_000_000;
  localparam int unsigned RtcHz         = 1_000_000;
  localparam int unsigned RtcHalfCycles = SocClkHz / (2 * RtcHz);

  // Board IO widths
  localparam int unsigned NumLeds      = 8;
  localparam int unsigned FanLevelBits = 4;
  localparam int unsigned BootModeBits = 2;
  localparam int unsigned SpiNumCs     = 2;
  localparam int unsigned SpiNumSd     = 4;

  // Register bus
  localparam int unsigned RegAddrBits = 8;
  localparam int unsigned RegDataBits = 32;
  localparam int unsigned RegCredits  = 2;

  // Register address map
  typedef enum logic [RegAddrBits-1:0] {
    REG_LED       = 8'h00,
    REG_FAN_LEVEL = 8'h04,
    REG_FAN_OVR   = 8'h08,
    REG_BOOT      = 8'h0C
  } reg_addr_e;

  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [RegAddrBits-1:0] addr;
    logic [RegDataBits-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                   valid;
    logic                   error;
    logic [RegDataBits-1:0] rdata;
  } reg_rsp_t;

  // SPI host outputs of the SoC, chip selects active low
  typedef struct packed {
    logic                sck;
    logic                sck_en;
    logic [SpiNumCs-1:0] csb;
    logic [SpiNumCs-1:0] csb_en;
    logic [SpiNumSd-1:0] sd_out;
    logic [SpiNumSd-1:0] sd_en;
  } spi_host_t;

  // SD card in SPI mode
  typedef struct packed {
    logic sclk;
    logic cmd;
    logic dat3;
    logic dat2;
    logic dat1;
  } sd_pins_t;

  typedef struct packed {
    logic                sck;
    logic                sck_oe;
    logic                csb;
    logic                csb_oe;
    logic [SpiNumSd-1:0] sd_out;
    logic [SpiNumSd-1:0] sd_oe;
  } flash_pins_t;

endpackage

//--- source/board_reset_sync.sv
//////////////////////////////////////////////////////////////////////
// Reset synchronizer, asynchronous assert and two-flop release,
// bypassed in test mode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_reset_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  output logic rst_sync_no
);

  logic [1:0] sync_q;

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Scan needs direct control of the reset
  assign rst_sync_no = test_mode_i ? rst_n : sync_q[1];

endmodule

//--- source/board_rtc_div.sv
//////////////////////////////////////////////////////////////////////
// Real-time clock divider, toggles every RtcHalfCycles soc_clk cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_rtc_div (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  import board_shell_pkg::*;

  logic [$clog2(RtcHalfCycles)-1:0] count_q;
  logic                             rtc_q;
  logic                             wrap;

  assign wrap = (count_q == RtcHalfCycles - 1);

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      rtc_q   <= 1'b0;
    end else if (wrap) begin
      count_q <= '0;
      rtc_q   <= ~rtc_q;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

endmodule

//--- source/board_cfg_regs.sv
//////////////////////////////////////////////////////////////////////
// Board configuration registers behind a credit-based register bus
// Request queue, address decode, LED, fan and boot-mode fields
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_cfg_regs (
  input  logic                                     soc_clk,
  input  logic                                     rst_n,
  input  board_shell_pkg::reg_req_t                reg_req_i,
  output board_shell_pkg::reg_rsp_t                reg_rsp_o,
  input  logic [board_shell_pkg::FanLevelBits-1:0] fan_sw_i,
  input  logic [board_shell_pkg::BootModeBits-1:0] boot_mode_i,
  output logic [board_shell_pkg::NumLeds-1:0]      led_o,
  output logic [board_shell_pkg::FanLevelBits-1:0] fan_level_o,
  output logic [board_shell_pkg::BootModeBits-1:0] boot_mode_o
);

  import board_shell_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Request queue
  //////////////////////////////////////////////////////////////////////

  reg_req_t                        queue_q [RegCredits];
  logic [$clog2(RegCredits)-1:0]   wr_ptr_q;
  logic [$clog2(RegCredits)-1:0]   rd_ptr_q;
  logic [$clog2(RegCredits+1)-1:0] count_q;
  logic                            push;
  logic                            pop;
  reg_req_t                        head;

  // Credits keep the requester from overrunning the queue
  assign push   = reg_req_i.valid;
  assign pop    = (count_q != '0);
  assign head   = queue_q[rd_ptr_q];

  always_ff @(posedge soc_clk) begin
    if (push) begin
      queue_q[wr_ptr_q] <= reg_req_i;
    end
  end

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == RegCredits - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == RegCredits - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decode and registers
  //////////////////////////////////////////////////////////////////////

  logic [NumLeds-1:0]      led_q;
  logic [FanLevelBits-1:0] fan_level_q;
  logic                    fan_ovr_q;
  logic [BootModeBits-1:0] boot_mode_q;
  logic                    boot_sel_q;
  logic                    addr_hit;
  logic [RegDataBits-1:0]  rdata;
  logic                    head_we;

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (head.addr)
      REG_LED:       rdata[NumLeds-1:0]      = led_q;
      REG_FAN_LEVEL: rdata[FanLevelBits-1:0] = fan_level_q;
      REG_FAN_OVR:   rdata[0]                = fan_ovr_q;
      REG_BOOT:      rdata[BootModeBits:0]   = {boot_sel_q, boot_mode_q};
      default:       addr_hit                = 1'b0;
    endcase
  end

  // Unmapped writes fall through without effect
  assign head_we = pop & head.write & addr_hit;

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      led_q       <= '0;
      fan_level_q <= '0;
      fan_ovr_q   <= 1'b0;
      boot_mode_q <= '0;
      boot_sel_q  <= 1'b0;
    end else begin
      if (head_we && head.addr == REG_LED) begin
        led_q <= head.wdata[NumLeds-1:0];
      end
      if (head_we && head.addr == REG_FAN_OVR) begin
        fan_ovr_q <= head.wdata[0];
      end
      // Switches own the level until software takes over
      if (!fan_ovr_q) begin
        fan_level_q <= fan_sw_i;
      end else if (head_we && head.addr == REG_FAN_LEVEL) begin
        fan_level_q <= head.wdata[FanLevelBits-1:0];
      end
      if (head_we && head.addr == REG_BOOT) begin
        boot_mode_q <= head.wdata[BootModeBits-1:0];
        boot_sel_q  <= head.wdata[BootModeBits];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response, one cycle after execution
  //////////////////////////////////////////////////////////////////////

  logic                   rsp_valid_q;
  logic                   rsp_error_q;
  logic [RegDataBits-1:0] rsp_rdata_q;

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= pop;
    end
  end

  always_ff @(posedge soc_clk) begin
    if (pop) begin
      rsp_error_q <= ~addr_hit;
      rsp_rdata_q <= rdata;
    end
  end

  always_comb begin
    reg_rsp_o.valid = rsp_valid_q;
    reg_rsp_o.error = rsp_error_q;
    reg_rsp_o.rdata = rsp_rdata_q;
  end

  assign led_o       = led_q;
  assign fan_level_o = fan_level_q;
  assign boot_mode_o = boot_sel_q ? boot_mode_q : boot_mode_i;

endmodule

//--- source/board_fan_pwm.sv
//////////////////////////////////////////////////////////////////////
// Fan PWM, 16-step window with the level as high time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_fan_pwm (
  input  logic                                     soc_clk,
  input  logic                                     rst_n,
  input  logic [board_shell_pkg::FanLevelBits-1:0] fan_level_i,
  output logic                                     fan_pwm_o
);

  import board_shell_pkg::*;

  logic [FanLevelBits-1:0] step_q;
  logic                    pwm_q;

  // Step counter wraps on its own
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      step_q <= '0;
      pwm_q  <= 1'b0;
    end else begin
      step_q <= step_q + 1'b1;
      pwm_q  <= (step_q < fan_level_i);
    end
  end

  // Level 0 keeps the fan off
  assign fan_pwm_o = pwm_q;

endmodule

//--- source/board_spi_pinmux.sv
//////////////////////////////////////////////////////////////////////
// SPI pin multiplexing between SD card (CS0) and QSPI flash (CS1)
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_spi_pinmux (
  input  board_shell_pkg::spi_host_t           spi_host_i,
  input  logic                                 sd_dat0_i,
  input  logic [board_shell_pkg::SpiNumSd-1:0] flash_sd_i,
  output board_shell_pkg::sd_pins_t            sd_pins_o,
  output board_shell_pkg::flash_pins_t         flash_pins_o,
  output logic [board_shell_pkg::SpiNumSd-1:0] spi_sd_in_o
);

  import board_shell_pkg::*;

  logic [SpiNumSd-1:0] sd_in;

  // SD card pins idle high when not driven
  assign sd_pins_o.sclk = spi_host_i.sck_en    ? spi_host_i.sck       : 1'b1;
  assign sd_pins_o.dat3 = spi_host_i.csb_en[0] ? spi_host_i.csb[0]    : 1'b1;
  assign sd_pins_o.cmd  = spi_host_i.sd_en[0]  ? spi_host_i.sd_out[0] : 1'b1;
  // Unused in SPI mode
  assign sd_pins_o.dat2 = 1'b1;
  assign sd_pins_o.dat1 = 1'b1;

  // Flash pins with separate output enables
  assign flash_pins_o.sck    = spi_host_i.sck;
  assign flash_pins_o.sck_oe = spi_host_i.sck_en;
  assign flash_pins_o.csb    = spi_host_i.csb[1];
  assign flash_pins_o.csb_oe = spi_host_i.csb_en[1];
  assign flash_pins_o.sd_out = spi_host_i.sd_out;
  assign flash_pins_o.sd_oe  = spi_host_i.sd_en;

  // MISO from DAT0 lands on host line 1
  always_comb begin
    sd_in    = '0;
    sd_in[1] = sd_dat0_i;
  end

  // Merge by active-low chip select
  assign spi_sd_in_o = ({SpiNumSd{~spi_host_i.csb[0]}} & sd_in)
                     | ({SpiNumSd{~spi_host_i.csb[1]}} & flash_sd_i);

endmodule

//--- source/board_shell_top.sv
//////////////////////////////////////////////////////////////////////
// Board shell top level, reset sync, RTC divider, config registers,
// fan PWM and SPI pin multiplexing around the external SoC core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_shell_top (
  input  logic                                     soc_clk,
  input  logic                                     rst_n,
  input  logic                                     test_mode_i,
  input  logic [board_shell_pkg::BootModeBits-1:0] boot_mode_i,
  output logic [board_shell_pkg::BootModeBits-1:0] boot_mode_o,
  input  logic [board_shell_pkg::FanLevelBits-1:0] fan_sw_i,
  output logic                                     fan_pwm_o,
  output logic [board_shell_pkg::NumLeds-1:0]      led_o,
  output logic                                     rtc_o,
  input  board_shell_pkg::reg_req_t                reg_req_i,
  output board_shell_pkg::reg_rsp_t                reg_rsp_o,
  input  board_shell_pkg::spi_host_t               spi_host_i,
  output logic [board_shell_pkg::SpiNumSd-1:0]     spi_sd_in_o,
  output board_shell_pkg::sd_pins_t                sd_pins_o,
  input  logic                                     sd_dat0_i,
  output board_shell_pkg::flash_pins_t             flash_pins_o,
  input  logic [board_shell_pkg::SpiNumSd-1:0]     flash_sd_i
);

  import board_shell_pkg::*;

  logic                    rst_sync_n;
  logic [FanLevelBits-1:0] fan_level;

  //////////////////////////////////////////////////////////////////////
  // Reset and clocking
  //////////////////////////////////////////////////////////////////////

  board_reset_sync i_reset_sync (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .test_mode_i ( test_mode_i ),
    .rst_sync_no ( rst_sync_n  )
  );

  board_rtc_div i_rtc_div (
    .soc_clk ( soc_clk    ),
    .rst_n   ( rst_sync_n ),
    .rtc_o   ( rtc_o      )
  );

  //////////////////////////////////////////////////////////////////////
  // Board control
  //////////////////////////////////////////////////////////////////////

  board_cfg_regs i_cfg_regs (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_sync_n  ),
    .reg_req_i   ( reg_req_i   ),
    .reg_rsp_o   ( reg_rsp_o   ),
    .fan_sw_i    ( fan_sw_i    ),
    .boot_mode_i ( boot_mode_i ),
    .led_o       ( led_o       ),
    .fan_level_o ( fan_level   ),
    .boot_mode_o ( boot_mode_o )
  );

  board_fan_pwm i_fan_pwm (
    .soc_clk     ( soc_clk    ),
    .rst_n       ( rst_sync_n ),
    .fan_level_i ( fan_level  ),
    .fan_pwm_o   ( fan_pwm_o  )
  );

  // SPI pins, no clock involved
  board_spi_pinmux i_spi_pinmux (
    .spi_host_i   ( spi_host_i   ),
    .sd_dat0_i    ( sd_dat0_i    ),
    .flash_sd_i   ( flash_sd_i   ),
    .sd_pins_o    ( sd_pins_o    ),
    .flash_pins_o ( flash_pins_o ),
    .spi_sd_in_o  ( spi_sd_in_o  )
  );

endmodule

//--- test/tb_board_shell.sv
//////////////////////////////////////////////////////////////////////
// Board shell testbench, credit-based register driver, in-order
// response checker, reset, RTC, fan, boot-mode and SPI checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_board_shell;

  import board_shell_pkg::*;

  localparam int RtcExpHalf = 50_000_000 / (2 * 1_000_000);

  // One outstanding register request and what it must return
  typedef struct packed {
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic        exp_error;
    logic        chk_rdata;
    logic [31:0] exp_rdata;
    logic [31:0] issue_cyc;
  } expect_t;

  logic                    soc_clk = 1'b0;
  logic                    rst_n;
  logic                    test_mode_i;
  logic [BootModeBits-1:0] boot_mode_i;
  logic [BootModeBits-1:0] boot_mode_o;
  logic [FanLevelBits-1:0] fan_sw_i;
  logic                    fan_pwm_o;
  logic [NumLeds-1:0]      led_o;
  logic                    rtc_o;
  reg_req_t                reg_req_i;
  reg_rsp_t                reg_rsp_o;
  spi_host_t               spi_host_i;
  logic [SpiNumSd-1:0]     spi_sd_in_o;
  sd_pins_t                sd_pins_o;
  logic                    sd_dat0_i;
  flash_pins_t             flash_pins_o;
  logic [SpiNumSd-1:0]     flash_sd_i;

  integer      seed = 74;
  int          cyc = 0;
  int          req_count = 0;
  int          rsp_count = 0;
  logic        saw_full = 1'b0;
  expect_t     exp_q[$];
  // Reference state of the register file
  logic [7:0]  led_m = '0;
  logic        fan_ovr_m = 1'b0;
  logic [3:0]  fan_lvl_m = '0;
  logic [2:0]  boot_m = '0;

  board_shell_top uut (.*);

  always #2 soc_clk = ~soc_clk;

  always @(posedge soc_clk) cyc <= cyc + 1;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act)
      else fail_now($sformatf("mismatch at %0t ns: %s expected 0x%0h actual 0x%0h",
                              $time, name, exp, act));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Register bus driver and response checker
  //////////////////////////////////////////////////////////////////////

  task automatic issue(input logic write, input logic [7:0] addr, input logic [31:0] wdata);
    expect_t e;
    int      n;
    n = 0;
    @(posedge soc_clk);
    while (req_count - rsp_count >= RegCredits) begin
      reg_req_i <= '0;
      n++;
      if (n > 8 * RegCredits) fail_now("no credit came back on the register bus");
      @(posedge soc_clk);
    end
    reg_req_i <= {1'b1, write, addr, wdata};
    e = '0;
    e.write = write;
    e.addr = addr;
    e.wdata = wdata;
    e.chk_rdata = !write;
    e.issue_cyc = cyc;
    case (addr)
      REG_LED: begin
        e.exp_rdata = led_m;
        if (write) led_m = wdata[7:0];
      end
      REG_FAN_LEVEL: begin
        e.exp_rdata = fan_ovr_m ? fan_lvl_m : fan_sw_i;
        if (write && fan_ovr_m) fan_lvl_m = wdata[3:0];
      end
      REG_FAN_OVR: begin
        e.exp_rdata = fan_ovr_m;
        if (write) fan_ovr_m = wdata[0];
        if (write) fan_lvl_m = fan_sw_i;
      end
      REG_BOOT: begin
        e.exp_rdata = boot_m;
        if (write) boot_m = wdata[2:0];
      end
      default: begin
        e.exp_error = 1'b1;
        e.chk_rdata = 1'b1;
      end
    endcase
    exp_q.push_back(e);
    req_count++;
    if (req_count - rsp_count == RegCredits) saw_full = 1'b1;
  endtask

  task automatic drain_bus();
    int n;
    n = 0;
    @(posedge soc_clk);
    reg_req_i <= '0;
    while (rsp_count != req_count) begin
      n++;
      if (n > 4 * RegCredits + 4) fail_now("register responses did not arrive");
      @(posedge soc_clk);
    end
  endtask

  task automatic check_response();
    expect_t e;
    assert (exp_q.size() > 0) else fail_now("response without an outstanding request");
    e = exp_q.pop_front();
    // Capture edge comes on top of the queue latency
    assert (cyc - e.issue_cyc <= RegCredits + 1)
      else fail_now($sformatf("response at %0t ns came too late", $time));
    check_value("reg_rsp_o.error", e.exp_error, reg_rsp_o.error);
    if (e.chk_rdata) check_value("reg_rsp_o.rdata", e.exp_rdata, reg_rsp_o.rdata);
    if (e.write && e.addr == REG_LED) check_value("led_o", e.wdata[7:0], led_o);
    rsp_count <= rsp_count + 1;
  endtask

  always @(posedge soc_clk) begin
    if (rst_n && reg_rsp_o.valid) check_response();
  end

  //////////////////////////////////////////////////////////////////////
  // Timing measurements
  //////////////////////////////////////////////////////////////////////

  task automatic wait_rtc_toggle(output int at);
    logic last;
    int   n;
    last = rtc_o;
    n = 0;
    @(posedge soc_clk);
    while (rtc_o == last) begin
      n++;
      if (n > 2 * RtcExpHalf) fail_now("rtc_o stopped toggling");
      @(posedge soc_clk);
    end
    at = cyc;
  endtask

  // Any 16 consecutive cycles hold one full PWM period
  task automatic check_duty(input logic [3:0] level);
    int high;
    repeat (3) @(posedge soc_clk);
    repeat (2) begin
      high = 0;
      repeat (16) begin
        @(posedge soc_clk);
        if (fan_pwm_o) high++;
      end
      check_value("fan_pwm_o high cycles", level, high);
    end
  endtask

  initial begin
    int          r;
    int          t0;
    int          t1;
    logic [3:0]  lvl;
    logic [1:0]  bm;
    spi_host_t   sh;
    logic [3:0]  sd_in_exp;
    rst_n = 1'b0;
    test_mode_i = 1'b0;
    boot_mode_i = 2'b10;
    fan_sw_i = '0;
    reg_req_i = '0;
    spi_host_i = '0;
    sd_dat0_i = 1'b0;
    flash_sd_i = '0;
    repeat (3) @(posedge soc_clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge soc_clk);

    // Reset values and RTC period
    check_value("led_o", 0, led_o);
    check_value("fan_pwm_o", 0, fan_pwm_o);
    check_value("reg_rsp_o.valid", 0, reg_rsp_o.valid);
    check_value("boot_mode_o", boot_mode_i, boot_mode_o);
    wait_rtc_toggle(t0);
    repeat (4) begin
      wait_rtc_toggle(t1);
      check_value("rtc_o half period", RtcExpHalf, t1 - t0);
      t0 = t1;
    end

    // Random LED traffic with some unmapped accesses mixed in
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0, 2'd1: issue(1'b1, REG_LED, $random(seed));
        2'd2:       issue(1'b0, REG_LED, '0);
        default:    issue(r[2], {r[7:2], 2'b01}, $random(seed));
      endcase
    end
    issue(1'b0, REG_LED, '0);
    drain_bus();
    assert (saw_full) else fail_now("register traffic never used up all credits");

    // Fan level follows the switches until the override is set
    r = $random(seed);
    lvl = r[3:0];
    fan_sw_i <= lvl;
    repeat (3) @(posedge soc_clk);
    issue(1'b0, REG_FAN_LEVEL, '0);
    drain_bus();
    check_duty(lvl);
    issue(1'b1, REG_FAN_OVR, 32'h1);
    issue(1'b1, REG_FAN_LEVEL, {28'h0, ~lvl});
    drain_bus();
    // Differs from both the old switch value and the written level
    fan_sw_i <= lvl ^ 4'h5;
    repeat (3) @(posedge soc_clk);
    issue(1'b0, REG_FAN_LEVEL, '0);
    issue(1'b0, REG_FAN_OVR, '0);
    drain_bus();
    check_duty(~lvl);

    // Boot mode override and release
    bm = ~boot_mode_i;
    issue(1'b1, REG_BOOT, {29'h0, 1'b1, bm});
    issue(1'b0, REG_BOOT, '0);
    drain_bus();
    check_value("boot_mode_o", bm, boot_mode_o);
    boot_mode_i <= 2'b11;
    issue(1'b1, REG_BOOT, '0);
    drain_bus();
    check_value("boot_mode_o", 2'b11, boot_mode_o);

    // SPI routing, chip selects are active low
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      sh = r[13:0];
      case (i % 4)
        0: sh.csb = 2'b10;
        1: sh.csb = 2'b01;
        2: sh.csb = 2'b11;
        default: sh.csb = sh.csb;
      endcase
      if (i % 4 == 2) begin
        sh.sck_en = 1'b0;
        sh.csb_en = '0;
        sh.sd_en = '0;
      end
      spi_host_i <= sh;
      sd_dat0_i <= r[14];
      flash_sd_i <= r[18:15];
      @(posedge soc_clk);
      @(posedge soc_clk);
      sd_in_exp = ({2'b00, r[14], 1'b0} & {4{~sh.csb[0]}}) | (r[18:15] & {4{~sh.csb[1]}});
      check_value("spi_sd_in_o", sd_in_exp, spi_sd_in_o);
      check_value("sd_pins_o", {sh.sck_en ? sh.sck : 1'b1, sh.sd_en[0] ? sh.sd_out[0] : 1'b1,
                                sh.csb_en[0] ? sh.csb[0] : 1'b1, 2'b11}, sd_pins_o);
      check_value("flash_pins_o", {sh.sck, sh.sck_en, sh.csb[1], sh.csb_en[1],
                                   sh.sd_out, sh.sd_en}, flash_pins_o);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- board_shell.f
source/board_shell_pkg.sv
source/board_reset_sync.sv
source/board_rtc_div.sv
source/board_cfg_regs.sv
source/board_fan_pwm.sv
source/board_spi_pinmux.sv
source/board_shell_top.sv
test/tb_board_shell.sv

//--- Bender.yml
package:
  name: board_shell

sources:
  - source/board_shell_pkg.sv
  - source/board_reset_sync.sv
  - source/board_rtc_div.sv
  - source/board_cfg_regs.sv
  - source/board_fan_pwm.sv
  - source/board_spi_pinmux.sv
  - source/board_shell_top.sv
  - target: test
    files:
      - test/tb_board_shell.sv
